// File: files.f
hw/eth_rx_pkg.sv
hw/rx_word_if.sv
hw/rx_crc32.sv
hw/rx_frame_fsm.sv
hw/rx_word_packer.sv
hw/rx_stats_regs.sv
hw/eth_rx_mac_top.sv
tb/tb_clock_gen.sv
tb/tb_eth_rx_mac.sv

// File: hw/eth_rx_mac_top.sv
`timescale 1ns/1ps

module eth_rx_mac_top #(
	parameter int COUNT_WIDTH = 32
) (
	input  logic        gmii_rx_clk,
	input  logic        arst_n,
	// GMII receive side, one byte per clock
	input  logic        rx_dv,
	input  logic        rx_er,
	input  logic [7:0]  rxd,
	// Words and verdicts to the upper layer
	output logic        rx_start,
	output logic        rx_valid,
	output logic [31:0] rx_data,
	output logic [2:0]  rx_bytes_valid,
	output logic        rx_commit,
	output logic        rx_drop,
	// APB statistics port
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	logic       crc_clear;
	logic       crc_update;
	logic       crc_match;
	logic       crc_check_en;
	logic       frame_start;
	logic       byte_push;
	logic       frame_end;
	logic [7:0] byte_data;

	rx_word_if u_words ();

	rx_frame_fsm u_fsm (
		.gmii_rx_clk  (gmii_rx_clk),
		.arst_n       (arst_n),
		.rx_dv        (rx_dv),
		.rx_er        (rx_er),
		.rxd          (rxd),
		.crc_check_en (crc_check_en),
		.crc_match    (crc_match),
		.crc_clear    (crc_clear),
		.crc_update   (crc_update),
		.frame_start  (frame_start),
		.byte_push    (byte_push),
		.frame_end    (frame_end),
		.byte_data    (byte_data),
		.status       (u_words.source)
	);

	rx_crc32 u_crc (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.crc_clear   (crc_clear),
		.crc_update  (crc_update),
		.din         (byte_data),
		.crc_match   (crc_match)
	);

	rx_word_packer u_packer (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.frame_start (frame_start),
		.byte_push   (byte_push),
		.byte_data   (byte_data),
		.frame_end   (frame_end),
		.words       (u_words.source)
	);

	rx_stats_regs #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_stats (
		.gmii_rx_clk  (gmii_rx_clk),
		.arst_n       (arst_n),
		.words        (u_words.sink),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.crc_check_en (crc_check_en)
	);

	// Word path out as plain ports
	assign rx_start       = u_words.start;
	assign rx_valid       = u_words.word_valid;
	assign rx_data        = u_words.data;
	assign rx_bytes_valid = u_words.bytes_valid;
	assign rx_commit      = u_words.commit;
	assign rx_drop        = u_words.drop;

endmodule

// File: hw/eth_rx_pkg.sv
package eth_rx_pkg;

	//////////////////////////////////////////////////////////////////////
	// Receive FSM states

	// Frame state, shared with the testbench for the reset check
	typedef enum logic [3:0] {
		st_idle       = 4'h0,
		st_preamble   = 4'h1,
		st_frame_data = 4'h2,
		st_check      = 4'h3,
		st_drop       = 4'h4
	} rx_state_e;

	//////////////////////////////////////////////////////////////////////
	// APB register map

	// Byte offsets of the statistics registers
	typedef enum logic [7:0] {
		reg_ctrl   = 8'h00,
		reg_frames = 8'h04,
		reg_drops  = 8'h08,
		reg_bytes  = 8'h0c
	} reg_addr_e;

	//////////////////////////////////////////////////////////////////////
	// Ethernet constants

	// Preamble fill byte and start of frame delimiter
	localparam logic [7:0] eth_preamble = 8'h55;
	localparam logic [7:0] eth_sfd      = 8'hd5;

	// CRC-32 remainder over payload plus a good FCS
	// Preset to all ones, no final inversion, normal bit order
	localparam logic [31:0] crc_residue = 32'hc704dd7b;

endpackage

// File: hw/rx_crc32.sv
`timescale 1ns/1ps

module rx_crc32 (
	input  logic       gmii_rx_clk,
	input  logic       arst_n,
	input  logic       crc_clear,
	input  logic       crc_update,
	input  logic [7:0] din,
	output logic       crc_match
);

	// Reflected polynomial of IEEE 802.3 CRC-32
	localparam logic [31:0] crc_poly = 32'hedb88320;

	logic [31:0] crc_q;
	logic [31:0] crc_rev;

	// One byte through the LSB-first CRC, bit 0 of the byte goes first
	function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] d);
		logic [31:0] c;
		c = crc_in;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ d[i]) begin
				c = (c >> 1) ^ crc_poly;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	// Clear wins over update, both never come together from the FSM
	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			crc_q <= '1;
		end else if (crc_clear) begin
			crc_q <= '1;
		end else if (crc_update) begin
			crc_q <= crc_byte(crc_q, din);
		end
	end

	// Register holds the CRC bit-reversed
	// Turn it back into normal order before comparing with the residue
	assign crc_rev = {<<{crc_q}};

	assign crc_match = (crc_rev == eth_rx_pkg::crc_residue);

endmodule

// File: hw/rx_frame_fsm.sv
`timescale 1ns/1ps

module rx_frame_fsm (
	input  logic       gmii_rx_clk,
	input  logic       arst_n,
	input  logic       rx_dv,
	input  logic       rx_er,
	input  logic [7:0] rxd,
	input  logic       crc_check_en,
	input  logic       crc_match,
	output logic       crc_clear,
	output logic       crc_update,
	output logic       frame_start,
	output logic       byte_push,
	output logic       frame_end,
	output logic [7:0] byte_data,
	rx_word_if.source  status
);

	eth_rx_pkg::rx_state_e state;
	eth_rx_pkg::rx_state_e state_nxt;

	// Bytes after the SFD, stops at 4 since only the runt rule needs it
	logic [2:0] byte_cnt;
	logic       sfd_hit;
	logic       frame_ok;

	//////////////////////////////////////////////////////////////////////
	// Steering for the CRC and the packer

	// Clean SFD while in the preamble opens a frame
	assign sfd_hit = (state == eth_rx_pkg::st_preamble) && rx_dv && !rx_er
		&& (rxd == eth_rx_pkg::eth_sfd);

	assign frame_start = sfd_hit;
	assign crc_clear   = sfd_hit;

	// Every frame byte, FCS included, goes to both data blocks
	assign byte_push  = (state == eth_rx_pkg::st_frame_data) && rx_dv;
	assign crc_update = byte_push;
	assign byte_data  = rxd;

	// rx_dv low inside the frame closes it
	assign frame_end = (state == eth_rx_pkg::st_frame_data) && !rx_dv;

	// Runt frames fail even with CRC checking off
	assign frame_ok = (byte_cnt == 3'd4) && (crc_match || !crc_check_en);

	//////////////////////////////////////////////////////////////////////
	// State transitions

	always_comb begin
		state_nxt = state;
		case (state)
			eth_rx_pkg::st_idle: begin
				// Anything but a clean preamble byte is skipped to the end
				if (rx_dv) begin
					if (!rx_er && (rxd == eth_rx_pkg::eth_preamble)) begin
						state_nxt = eth_rx_pkg::st_preamble;
					end else begin
						state_nxt = eth_rx_pkg::st_drop;
					end
				end
			end
			eth_rx_pkg::st_preamble: begin
				if (!rx_dv) begin
					state_nxt = eth_rx_pkg::st_idle;
				end else if (sfd_hit) begin
					state_nxt = eth_rx_pkg::st_frame_data;
				end else if (rx_er || (rxd != eth_rx_pkg::eth_preamble)) begin
					state_nxt = eth_rx_pkg::st_drop;
				end
			end
			eth_rx_pkg::st_frame_data: begin
				if (!rx_dv) begin
					state_nxt = eth_rx_pkg::st_check;
				end
			end
			// One cycle for the packer flush, then the verdict
			eth_rx_pkg::st_check: state_nxt = eth_rx_pkg::st_idle;
			eth_rx_pkg::st_drop: begin
				if (!rx_dv) begin
					state_nxt = eth_rx_pkg::st_idle;
				end
			end
			default: state_nxt = eth_rx_pkg::st_idle;
		endcase
	end

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= eth_rx_pkg::st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// Byte counter for the short frame rule
	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			byte_cnt <= '0;
		end else if (sfd_hit) begin
			byte_cnt <= '0;
		end else if (byte_push && (byte_cnt != 3'd4)) begin
			byte_cnt <= byte_cnt + 3'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Verdict

	// Decided in the check cycle, the last CRC update has settled by then
	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			status.commit <= 1'b0;
			status.drop   <= 1'b0;
		end else begin
			status.commit <= (state == eth_rx_pkg::st_check) && frame_ok;
			status.drop   <= (state == eth_rx_pkg::st_check) && !frame_ok;
		end
	end

	// Closed frame gets one verdict two cycles on, never both
	a_one_verdict: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
		frame_end |-> ##2 (status.commit ^ status.drop));

endmodule

// File: hw/rx_stats_regs.sv
`timescale 1ns/1ps

module rx_stats_regs #(
	parameter int COUNT_WIDTH = 32
) (
	input  logic        gmii_rx_clk,
	input  logic        arst_n,
	rx_word_if.sink     words,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        crc_check_en
);

	logic [COUNT_WIDTH-1:0] frames_q;
	logic [COUNT_WIDTH-1:0] drops_q;
	logic [COUNT_WIDTH-1:0] bytes_q;

	// Payload bytes of the frame in flight, taken back on drop
	logic [COUNT_WIDTH-1:0] frame_bytes_q;

	eth_rx_pkg::reg_addr_e addr;
	logic        apb_write;
	logic        ctrl_write;
	logic        clear_cnt;
	logic        addr_hit;
	logic [31:0] rdata;

	//////////////////////////////////////////////////////////////////////
	// APB decode

	assign addr       = eth_rx_pkg::reg_addr_e'(paddr);
	assign apb_write  = psel && penable && pwrite;
	assign ctrl_write = apb_write && (addr == eth_rx_pkg::reg_ctrl);

	// Self clearing, never stored
	assign clear_cnt = ctrl_write && pwdata[1];

	always_comb begin
		rdata    = '0;
		addr_hit = 1'b1;
		case (addr)
			eth_rx_pkg::reg_ctrl:   rdata = {31'd0, crc_check_en};
			eth_rx_pkg::reg_frames: rdata = 32'(frames_q);
			eth_rx_pkg::reg_drops:  rdata = 32'(drops_q);
			eth_rx_pkg::reg_bytes:  rdata = 32'(bytes_q);
			default:                addr_hit = 1'b0;
		endcase
	end

	// No wait states
	assign pready  = 1'b1;
	assign prdata  = (psel && !pwrite) ? rdata : 32'd0;
	assign pslverr = psel && penable && !addr_hit;

	// CRC check on out of reset
	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			crc_check_en <= 1'b1;
		end else if (ctrl_write) begin
			crc_check_en <= pwdata[0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Counters

	// Commit and drop come one cycle after the last word, never together with it
	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			frames_q      <= '0;
			drops_q       <= '0;
			bytes_q       <= '0;
			frame_bytes_q <= '0;
		end else if (clear_cnt) begin
			frames_q      <= '0;
			drops_q       <= '0;
			bytes_q       <= '0;
			frame_bytes_q <= '0;
		end else begin
			if (words.start) begin
				frame_bytes_q <= '0;
			end else if (words.word_valid) begin
				frame_bytes_q <= frame_bytes_q + COUNT_WIDTH'(words.bytes_valid);
			end
			if (words.word_valid) begin
				bytes_q <= bytes_q + COUNT_WIDTH'(words.bytes_valid);
			end else if (words.drop) begin
				bytes_q <= bytes_q - frame_bytes_q;
			end
			if (words.commit) begin
				frames_q <= frames_q + 1'b1;
			end
			if (words.drop) begin
				drops_q <= drops_q + 1'b1;
			end
		end
	end

	a_penable_in_psel: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
		penable |-> psel);

endmodule

// File: hw/rx_word_if.sv
`timescale 1ns/1ps

// Word and frame status path from the receive core to the statistics block
// All signals are single cycle strobes, no handshake
interface rx_word_if;

	// SFD seen, frame begins
	logic        start;

	// Packed payload word, big-endian
	logic        word_valid;
	logic [31:0] data;

	// Number of valid bytes in data, 1 to 4, counted from the top
	logic [2:0]  bytes_valid;

	// Frame verdict, one of the two per started frame
	logic        commit;
	logic        drop;

	// Packer drives the word side, the FSM drives the verdict side
	modport source (
		output start, word_valid, data, bytes_valid, commit, drop
	);

	modport sink (
		input start, word_valid, data, bytes_valid, commit, drop
	);

endinterface

// File: hw/rx_word_packer.sv
`timescale 1ns/1ps

module rx_word_packer (
	input  logic       gmii_rx_clk,
	input  logic       arst_n,
	input  logic       frame_start,
	input  logic       byte_push,
	input  logic [7:0] byte_data,
	input  logic       frame_end,
	rx_word_if.source  words
);

	// Four byte hold back, the FCS never leaves it
	logic [31:0] delay_q;
	logic [2:0]  fill_q;

	// Bytes of the word being built, newest in the low byte
	logic [23:0] acc_q;
	logic [1:0]  pos_q;

	logic [7:0]  out_byte;
	logic        byte_out;
	logic        word_full;

	assign out_byte  = delay_q[31:24];
	assign byte_out  = byte_push && (fill_q == 3'd4);
	assign word_full = byte_out && (pos_q == 2'd3);

	// Payload path
	always_ff @(posedge gmii_rx_clk) begin
		if (byte_push) begin
			delay_q <= {delay_q[23:0], byte_data};
		end
		if (byte_out) begin
			acc_q <= {acc_q[15:0], out_byte};
		end
	end

	// Fill level of the delay and byte lane of the word
	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			fill_q <= '0;
			pos_q  <= '0;
		end else if (frame_start || frame_end) begin
			fill_q <= '0;
			pos_q  <= '0;
		end else if (byte_push) begin
			if (fill_q != 3'd4) begin
				fill_q <= fill_q + 3'd1;
			end
			if (byte_out) begin
				pos_q <= pos_q + 2'd1;   // wraps after the fourth lane
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Word output

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			words.start       <= 1'b0;
			words.word_valid  <= 1'b0;
			words.bytes_valid <= '0;
		end else begin
			words.start       <= frame_start;
			words.word_valid  <= word_full || (frame_end && (pos_q != 2'd0));
			words.bytes_valid <= '0;
			if (word_full) begin
				words.bytes_valid <= 3'd4;
			end else if (frame_end) begin
				words.bytes_valid <= {1'b0, pos_q};
			end
		end
	end

	// Tail flush is left aligned, unused low bytes zero
	always_ff @(posedge gmii_rx_clk) begin
		if (word_full) begin
			words.data <= {acc_q, out_byte};
		end else if (frame_end) begin
			case (pos_q)
				2'd1:    words.data <= {acc_q[7:0], 24'h0};
				2'd2:    words.data <= {acc_q[15:0], 16'h0};
				2'd3:    words.data <= {acc_q, 8'h0};
				default: words.data <= '0;
			endcase
		end
	end

	a_valid_has_bytes: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
		words.word_valid |-> (words.bytes_valid != 3'd0));

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the receive MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_eth_rx_mac -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_eth_rx_mac)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
	exit 0
fi
exit 1

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

// Receive clock and power-on reset for the testbench
module tb_clock_gen #(
	parameter real half_period  = 2.0,
	parameter int  reset_cycles = 4
) (
	output logic gmii_rx_clk,
	output logic arst_n
);

	// 4 ns period, one GMII byte per cycle
	initial begin
		gmii_rx_clk = 1'b0;
		forever begin
			#(half_period) gmii_rx_clk = ~gmii_rx_clk;
		end
	end

	// Release on a falling edge, clear of the DUT sampling edge
	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge gmii_rx_clk);
		@(negedge gmii_rx_clk);
		arst_n = 1'b1;
	end

endmodule

// File: tb/tb_eth_rx_mac.sv
`timescale 1ns/1ps

module tb_eth_rx_mac;

	// Frame counts per test
	localparam int n_good  = 20;
	localparam int n_bad   = 15;
	localparam int n_pre   = 8;
	localparam int n_nocrc = 8;

	// Longest frame, 8 preamble plus 44 bytes plus verdict and gap, rounded up
	localparam int frame_cycles = 96;
	localparam int limit_cycles = (n_good + n_bad + n_pre + n_nocrc) * frame_cycles + 2000;

	logic        gmii_rx_clk;
	logic        arst_n;
	logic        rx_dv;
	logic        rx_er;
	logic [7:0]  rxd;
	logic        rx_start;
	logic        rx_valid;
	logic [31:0] rx_data;
	logic [2:0]  rx_bytes_valid;
	logic        rx_commit;
	logic        rx_drop;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	// Random source and model state
	logic [31:0] lfsr = 32'h280c;
	logic [7:0]  frame_q[$];
	logic [31:0] exp_data_q[$];
	logic [2:0]  exp_bv_q[$];
	logic        exp_verdict_q[$];
	logic        exp_verdict;
	logic        crc_en_model = 1'b1;
	int          exp_starts = 0;
	int unsigned tot_frames = 0;
	int unsigned tot_drops = 0;
	int unsigned tot_bytes = 0;
	int          errors = 0;
	int          test_base = 0;
	int          checks = 0;

	tb_clock_gen u_clk (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n)
	);

	eth_rx_mac_top #(
		.COUNT_WIDTH (32)
	) u_dut (.*);

	//////////////////////////////////////////////////////////////////////
	// Helpers

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	// Ethernet CRC-32, reflected form, one byte LSB first
	function automatic logic [31:0] crc_add(input logic [31:0] crc, input logic [7:0] b);
		logic [31:0] c;
		c = crc ^ {24'h0, b};
		for (int k = 0; k < 8; k++) begin
			c = (c >> 1) ^ (c[0] ? 32'hedb88320 : 32'h0);
		end
		return c;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			$display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			$display("ERROR at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("test %-12s %s, %0d errors", name,
			(errors == test_base) ? "ok" : "failed", errors - test_base);
		test_base = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model

	// kind 0 good, 1 one byte corrupted, 2 runt of 1 to 3 bytes
	task automatic build_frame(input int kind, input logic started);
		int          len;
		int          flip;
		int          pos;
		logic [31:0] crc;
		logic [31:0] rev;
		logic [31:0] word;
		logic        ok;
		frame_q.delete();
		if (kind == 2) begin
			len = 1 + int'(rand_bits(2)) % 3;
			for (int i = 0; i < len; i++) begin
				frame_q.push_back(8'(rand_bits(8)));
			end
		end else begin
			len = 1 + int'(rand_bits(6)) % 40;
			crc = '1;
			for (int i = 0; i < len; i++) begin
				frame_q.push_back(8'(rand_bits(8)));
				crc = crc_add(crc, frame_q[i]);
			end
			// FCS is the inverted CRC, low byte on the wire first
			crc = ~crc;
			for (int i = 0; i < 4; i++) begin
				frame_q.push_back(crc[8*i +: 8]);
			end
			if (kind == 1) begin
				flip = int'(rand_bits(6)) % (len + 4);
				frame_q[flip] = frame_q[flip] ^ (8'(rand_bits(8)) | 8'h01);
			end
		end
		if (!started) begin
			return;
		end
		// Words from all but the last four bytes, big-endian, tail zero filled
		word = '0;
		pos  = 0;
		for (int i = 0; i < int'(frame_q.size()) - 4; i++) begin
			word = {word[23:0], frame_q[i]};
			pos++;
			if (pos == 4) begin
				exp_data_q.push_back(word);
				exp_bv_q.push_back(3'd4);
				word = '0;
				pos  = 0;
			end
		end
		if (pos != 0) begin
			exp_data_q.push_back(word << (8 * (4 - pos)));
			exp_bv_q.push_back(3'(pos));
		end
		// Verdict from the residue over everything after the SFD
		crc = '1;
		foreach (frame_q[i]) begin
			crc = crc_add(crc, frame_q[i]);
		end
		rev = {<<{crc}};
		ok  = (frame_q.size() >= 4) && (!crc_en_model || (rev == eth_rx_pkg::crc_residue));
		exp_verdict_q.push_back(ok);
		exp_starts++;
		if (ok) begin
			tot_frames++;
			tot_bytes += frame_q.size() - 4;
		end else begin
			tot_drops++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// GMII and APB drivers, all on the falling edge

	// bad_pos and er_pos pick a preamble byte to spoil, -1 for none
	task automatic drive_frame(input int bad_pos, input int er_pos, input logic [7:0] bad_val);
		int cnt;
		for (int i = 0; i < 8; i++) begin
			@(negedge gmii_rx_clk);
			rx_dv = 1'b1;
			rx_er = (i == er_pos);
			rxd   = (i == 7) ? eth_rx_pkg::eth_sfd : eth_rx_pkg::eth_preamble;
			if (i == bad_pos) begin
				rxd = bad_val;
			end
		end
		foreach (frame_q[i]) begin
			@(negedge gmii_rx_clk);
			rx_er = 1'b0;
			rxd   = frame_q[i];
		end
		@(negedge gmii_rx_clk);
		rx_dv = 1'b0;
		rxd   = 8'h00;
		// Verdict arrives a few cycles after rx_dv falls
		cnt = 0;
		while ((exp_verdict_q.size() != 0) && (cnt < 16)) begin
			@(negedge gmii_rx_clk);
			cnt++;
		end
		check_true(exp_verdict_q.size() == 0, "frame ended without commit or drop");
		check_true(exp_data_q.size() == 0, "payload words missing at frame end");
		check_true(exp_starts == 0, "started frame gave no rx_start");
		exp_verdict_q.delete();
		exp_data_q.delete();
		exp_bv_q.delete();
		exp_starts = 0;
		repeat (4 + rand_bits(3)) @(negedge gmii_rx_clk);
	endtask

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge gmii_rx_clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge gmii_rx_clk);
		penable = 1'b1;
		// Access phase completes on the rising edge in between
		@(negedge gmii_rx_clk);
		check_eq("pready", 32'h1, 32'(pready));
		rdata   = prdata;
		err     = pslverr;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string name);
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b0, addr, 32'h0, rd, err);
		check_eq(name, exp, rd);
		check_eq("pslverr", 32'h0, 32'(err));
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b1, addr, wdata, rd, err);
		check_eq("pslverr", 32'h0, 32'(err));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output monitor, sampled on the falling edge

	always @(negedge gmii_rx_clk) begin
		if (arst_n) begin
			if (rx_start) begin
				check_true(exp_starts > 0, "rx_start with no frame started");
				if (exp_starts > 0) begin
					exp_starts--;
				end
			end
			if (rx_valid) begin
				if (exp_data_q.size() == 0) begin
					check_true(1'b0, "rx_valid with no payload word expected");
				end else begin
					check_eq("rx_data", exp_data_q.pop_front(), rx_data);
					check_eq("rx_bytes_valid", 32'(exp_bv_q.pop_front()), 32'(rx_bytes_valid));
				end
			end
			if (rx_commit || rx_drop) begin
				if (exp_verdict_q.size() == 0) begin
					check_true(1'b0, "commit or drop with no frame in flight");
				end else begin
					exp_verdict = exp_verdict_q.pop_front();
					check_eq("rx_commit", 32'(exp_verdict), 32'(rx_commit));
					check_eq("rx_drop", 32'(!exp_verdict), 32'(rx_drop));
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0] rd;
		logic        err;
		logic [7:0]  bad_val;
		int          bad_pos;
		int          er_pos;

		rx_dv   = 1'b0;
		rx_er   = 1'b0;
		rxd     = 8'h00;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = 8'h00;
		pwdata  = 32'h0;
		wait (arst_n === 1'b1);

		// Quiet outputs and register defaults out of reset
		check_eq("u_fsm.state", 32'(eth_rx_pkg::st_idle), 32'(u_dut.u_fsm.state));
		check_eq("prdata", 32'h0, prdata);
		check_eq("pslverr", 32'h0, 32'(pslverr));
		repeat (6) begin
			@(negedge gmii_rx_clk);
			check_eq("rx_start", 32'h0, 32'(rx_start));
			check_eq("rx_valid", 32'h0, 32'(rx_valid));
			check_eq("rx_commit", 32'h0, 32'(rx_commit));
			check_eq("rx_drop", 32'h0, 32'(rx_drop));
		end
		read_expect(eth_rx_pkg::reg_ctrl, 32'h1, "ctrl");
		read_expect(eth_rx_pkg::reg_frames, 32'h0, "frames");
		read_expect(eth_rx_pkg::reg_drops, 32'h0, "drops");
		read_expect(eth_rx_pkg::reg_bytes, 32'h0, "bytes");
		end_test("reset");

		for (int f = 0; f < n_good; f++) begin
			build_frame(0, 1'b1);
			drive_frame(-1, -1, 8'h00);
		end
		end_test("good");

		// Corrupted frames and runts, about one in four a runt
		for (int f = 0; f < n_bad; f++) begin
			build_frame((rand_bits(2) == 0) ? 2 : 1, 1'b1);
			drive_frame(-1, -1, 8'h00);
		end
		read_expect(eth_rx_pkg::reg_drops, tot_drops, "drops");
		end_test("bad_fcs");

		// Spoiled preamble, never 0x55 or the SFD as the bad byte
		for (int f = 0; f < n_pre; f++) begin
			build_frame(0, 1'b0);
			bad_val = 8'(rand_bits(8));
			if ((bad_val == eth_rx_pkg::eth_preamble) || (bad_val == eth_rx_pkg::eth_sfd)) begin
				bad_val = bad_val ^ 8'h01;
			end
			bad_pos = -1;
			er_pos  = -1;
			if (rand_bits(1) != 0) begin
				bad_pos = int'(rand_bits(3)) % 7;
			end else begin
				er_pos = int'(rand_bits(3)) % 7;
			end
			drive_frame(bad_pos, er_pos, bad_val);
		end
		end_test("preamble");

		// CRC check off, corrupted frames pass
		write_reg(eth_rx_pkg::reg_ctrl, 32'h0);
		crc_en_model = 1'b0;
		for (int f = 0; f < n_nocrc; f++) begin
			build_frame(1, 1'b1);
			drive_frame(-1, -1, 8'h00);
		end
		write_reg(eth_rx_pkg::reg_ctrl, 32'h1);
		crc_en_model = 1'b1;
		end_test("crc_off");

		// Totals, unmapped offset, counter clear
		read_expect(eth_rx_pkg::reg_frames, tot_frames, "frames");
		read_expect(eth_rx_pkg::reg_drops, tot_drops, "drops");
		read_expect(eth_rx_pkg::reg_bytes, tot_bytes, "bytes");
		apb_xfer(1'b0, 8'h10, 32'h0, rd, err);
		check_eq("pslverr", 32'h1, 32'(err));
		write_reg(eth_rx_pkg::reg_ctrl, 32'h3);
		read_expect(eth_rx_pkg::reg_frames, 32'h0, "frames");
		read_expect(eth_rx_pkg::reg_drops, 32'h0, "drops");
		read_expect(eth_rx_pkg::reg_bytes, 32'h0, "bytes");
		read_expect(eth_rx_pkg::reg_ctrl, 32'h1, "ctrl");
		end_test("counters");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog sized from the frame count
	initial begin
		repeat (limit_cycles) @(posedge gmii_rx_clk);
		$display("Watchdog expired after %0d cycles, the test sequence did not finish",
			limit_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule
